/* Bender.yml */
package:
  name: id_queue

sources:
  - id_queue_pkg.sv
  - head_tail_table.sv
  - linked_data_store.sv
  - exists_search.sv
  - id_queue_ctrl.sv
  - id_queue_top.sv
  - target: test
    files:
      - id_queue_props.sv
      - tb_id_queue.sv

/* exists_search.sv */
module exists_search (
    input  id_queue_pkg::linked_data_t [id_queue_pkg::CAPACITY-1:0] elems_i,
    input  id_queue_pkg::search_req_t                               search_i,
    input  logic                                                    search_req_i,
    output logic                                                    search_gnt_o,
    output logic                                                    exists_o
);
    import id_queue_pkg::*;

    logic [CAPACITY-1:0] hit;

    // A bit takes part in the comparison only where the mask is set
    // Free elements hold stale data and never count as a match
    always_comb begin
        for (int i = 0; i < CAPACITY; i++) begin
            hit[i] = !elems_i[i].free &&
                     (((elems_i[i].data ^ search_i.data) & search_i.mask) == '0);
        end
    end

    // The search port never stalls, so every request is granted at once
    assign search_gnt_o = search_req_i;

    assign exists_o = search_req_i && (|hit);

endmodule

/* files.f */
id_queue_pkg.sv
head_tail_table.sv
linked_data_store.sv
exists_search.sv
id_queue_ctrl.sv
id_queue_top.sv
id_queue_props.sv
tb_id_queue.sv

/* head_tail_table.sv */
module head_tail_table (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  id_queue_pkg::id_t        lookup_id_i,
    input  id_queue_pkg::ht_cmd_t    cmd_i,
    output logic                     match_o,
    output id_queue_pkg::head_tail_t match_entry_o,
    output id_queue_pkg::ht_idx_t    free_idx_o
);
    import id_queue_pkg::*;

    head_tail_t [HT_CAPACITY-1:0] entry_q;
    logic [HT_CAPACITY-1:0]       hit;
    ht_idx_t                      match_idx;
    ht_idx_t                      first_free;

    // Only occupied entries take part in the ID comparison
    always_comb begin
        for (int i = 0; i < HT_CAPACITY; i++) begin
            hit[i] = !entry_q[i].free && (entry_q[i].id == lookup_id_i);
        end
    end

    // IDs are unique among occupied entries, so at most one entry hits
    always_comb begin
        match_idx = '0;
        match_entry_o = '0;
        for (int i = 0; i < HT_CAPACITY; i++) begin
            if (hit[i]) begin
                match_idx = ht_idx_t'(i);
                match_entry_o = entry_q[i];
            end
        end
    end

    assign match_o = |hit;

    // Scan downwards so that the lowest free entry wins
    always_comb begin
        first_free = '0;
        for (int i = HT_CAPACITY - 1; i >= 0; i--) begin
            if (entry_q[i].free) begin
                first_free = ht_idx_t'(i);
            end
        end
    end

    // The slot of the lookup ID: its own entry if present, else the one a new entry opens in
    assign free_idx_o = match_o ? match_idx : first_free;

    // The target index comes with the command, no second match is needed here
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < HT_CAPACITY; i++) begin
                entry_q[i] <= '{id: '0, head: '0, tail: '0, free: 1'b1};
            end
        end else begin
            case (cmd_i.op)
                // Opening, appending and advancing the head all rewrite the entry
                OP_PUSH: begin
                    entry_q[cmd_i.idx] <= '{
                        id:   lookup_id_i,
                        head: cmd_i.head,
                        tail: cmd_i.tail,
                        free: 1'b0
                    };
                end
                // The last element of this ID left the queue
                OP_POP: begin
                    entry_q[cmd_i.idx] <= '{id: '0, head: '0, tail: '0, free: 1'b1};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* id_queue_ctrl.sv */
module id_queue_ctrl (
    input  id_queue_pkg::push_req_t    push_i,
    input  logic                       push_req_i,
    input  id_queue_pkg::read_req_t    read_i,
    input  logic                       read_req_i,
    input  logic                       full_i,
    input  logic                       match_i,
    input  id_queue_pkg::head_tail_t   match_entry_i,
    input  id_queue_pkg::ht_idx_t      ht_free_idx_i,
    input  id_queue_pkg::ld_idx_t      ld_free_idx_i,
    input  id_queue_pkg::linked_data_t head_elem_i,
    output id_queue_pkg::id_t          lookup_id_o,
    output id_queue_pkg::ht_cmd_t      ht_cmd_o,
    output id_queue_pkg::ld_cmd_t      ld_cmd_o,
    output logic                       push_gnt_o,
    output logic                       read_gnt_o,
    output id_queue_pkg::data_t        read_data_o,
    output logic                       read_valid_o
);
    import id_queue_pkg::*;

    q_op_e op;
    logic  push_fire;

    // Push wins, a read is only served in a cycle without a granted push
    assign push_gnt_o = !full_i;
    assign push_fire = push_req_i && !full_i;
    assign read_gnt_o = read_req_i && !push_fire;

    always_comb begin
        if (push_fire) begin
            op = OP_PUSH;
        end else if (read_gnt_o) begin
            op = read_i.pop ? OP_POP : OP_READ;
        end else begin
            op = OP_IDLE;
        end
    end

    // The one ID matcher serves whichever port owns this cycle
    assign lookup_id_o = push_fire ? push_i.id : read_i.id;

    // A read of an ID that is not stored returns invalid, zeroed data
    assign read_valid_o = read_gnt_o && match_i;
    assign read_data_o = read_valid_o ? head_elem_i.data : '0;

    always_comb begin
        ht_cmd_o = '{op: OP_IDLE, idx: ht_free_idx_i, head: '0, tail: '0};
        ld_cmd_o = '{op: OP_IDLE, idx: ld_free_idx_i, data: '0, link: '0, link_en: 1'b0};
        case (op)
            OP_PUSH: begin
                // A new ID opens its entry with head and tail on the new element
                // A known ID keeps its head and moves the tail
                ht_cmd_o.op = OP_PUSH;
                ht_cmd_o.head = match_i ? match_entry_i.head : ld_free_idx_i;
                ht_cmd_o.tail = ld_free_idx_i;
                ld_cmd_o = '{op: OP_PUSH, idx: ld_free_idx_i, data: push_i.data,
                             link: match_entry_i.tail, link_en: match_i};
            end
            OP_POP: begin
                if (match_i) begin
                    ld_cmd_o.op = OP_POP;
                    ld_cmd_o.idx = match_entry_i.head;
                    // With one element left the whole entry goes, else the head moves on
                    if (match_entry_i.head == match_entry_i.tail) begin
                        ht_cmd_o.op = OP_POP;
                    end else begin
                        ht_cmd_o.op = OP_PUSH;
                        ht_cmd_o.head = head_elem_i.next;
                        ht_cmd_o.tail = match_entry_i.tail;
                    end
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* id_queue_input.txt */
// Each line is one cycle with push_req push_id push_data read_req read_id read_pop
// search_req search_data search_mask and the expected push_gnt read_gnt read_valid read_data exists
1_1_1a01_1_1_0_1_1a01_ffff_1_0_0_0000_0
1_2_2b01_0_0_0_1_1a01_ffff_1_0_0_0000_1
0_0_0000_1_1_0_0_0000_0000_1_1_1_1a01_0
1_1_1a02_0_0_0_0_0000_0000_1_0_0_0000_0
1_2_2b02_0_0_0_0_0000_0000_1_0_0_0000_0
1_1_1a03_0_0_0_0_0000_0000_1_0_0_0000_0
0_0_0000_1_1_0_0_0000_0000_1_1_1_1a01_0
0_0_0000_1_5_1_0_0000_0000_1_1_0_0000_0
1_3_3c01_0_0_0_0_0000_0000_1_0_0_0000_0
1_2_2b03_0_0_0_0_0000_0000_1_0_0_0000_0
1_4_4d01_0_0_0_1_4d00_ff00_1_0_0_0000_0
1_5_5e01_0_0_0_1_4d00_ff00_0_0_0_0000_1
1_5_5e01_1_2_1_0_0000_0000_0_1_1_2b01_0
1_5_5e01_0_0_0_1_0000_0000_1_0_0_0000_1
0_0_0000_1_1_1_0_0000_0000_0_1_1_1a01_0
0_0_0000_1_2_1_0_0000_0000_1_1_1_2b02_0
0_0_0000_1_1_1_1_1a01_ffff_1_1_1_1a02_0
0_0_0000_1_1_1_0_0000_0000_1_1_1_1a03_0
0_0_0000_1_1_0_0_0000_0000_1_1_0_0000_0
0_0_0000_1_2_1_1_2b00_ff00_1_1_1_2b03_1
0_0_0000_1_2_0_1_2b00_ff00_1_1_0_0000_0
0_0_0000_1_5_1_1_0000_0000_1_1_1_5e01_1
0_0_0000_1_4_1_0_0000_0000_1_1_1_4d01_0
0_0_0000_1_3_1_1_0000_0000_1_1_1_3c01_1
0_0_0000_0_0_0_1_0000_0000_1_0_0_0000_0

/* id_queue_pkg.sv */
package id_queue_pkg;

    // Every element carries a 3-bit ID, so eight distinct IDs can be queued at once
    localparam int ID_WIDTH = 3;
    localparam int N_IDS = 2 ** ID_WIDTH;
    // Total number of elements, shared by all IDs
    localparam int CAPACITY = 8;
    localparam int DATA_WIDTH = 16;
    // The head-tail table never needs more entries than there are IDs or elements
    localparam int HT_CAPACITY = (N_IDS < CAPACITY) ? N_IDS : CAPACITY;
    localparam int HT_IDX_WIDTH = $clog2(HT_CAPACITY);
    localparam int LD_IDX_WIDTH = $clog2(CAPACITY);

    typedef logic [ID_WIDTH-1:0] id_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DATA_WIDTH-1:0] mask_t;
    typedef logic [HT_IDX_WIDTH-1:0] ht_idx_t;
    typedef logic [LD_IDX_WIDTH-1:0] ld_idx_t;

    // One sub-queue descriptor: the oldest and the newest element of one ID
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } head_tail_t;

    // One stored element with the link to the next younger element of the same ID
    typedef struct packed {
        data_t   data;
        ld_idx_t next;
        logic    free;
    } linked_data_t;

    typedef struct packed {
        id_t   id;
        data_t data;
    } push_req_t;

    typedef struct packed {
        id_t  id;
        logic pop;
    } read_req_t;

    typedef struct packed {
        data_t data;
        mask_t mask;
    } search_req_t;

    // Operation of one cycle, also used as the opcode of the table update commands
    typedef enum logic [1:0] {
        OP_IDLE = 2'd0,
        OP_PUSH = 2'd1,
        OP_READ = 2'd2,
        OP_POP  = 2'd3
    } q_op_e;

    // In the head-tail table OP_PUSH writes the whole entry and OP_POP frees it
    typedef struct packed {
        q_op_e   op;
        ht_idx_t idx;
        ld_idx_t head;
        ld_idx_t tail;
    } ht_cmd_t;

    // In the element store OP_PUSH writes a new element and may relink its predecessor
    typedef struct packed {
        q_op_e   op;
        ld_idx_t idx;
        data_t   data;
        ld_idx_t link;
        logic    link_en;
    } ld_cmd_t;

endpackage

/* id_queue_props.sv */
module id_queue_props (
    input logic clk_i,
    input logic rst_ni,
    input logic push_req_i,
    input logic push_gnt_o,
    input logic read_gnt_o,
    input logic read_valid_o,
    input logic search_req_i,
    input logic exists_o
);

    // Number of assertion failures, collected by the testbench at the end
    int fail_count = 0;

    // Read data is only valid inside a granted read
    valid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        read_valid_o |-> read_gnt_o)
        else begin
            $error("read_valid_o high without read_gnt_o");
            fail_count++;
        end

    // A push that takes place blocks the read port in the same cycle
    push_blocks_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push_req_i && push_gnt_o) |-> !read_gnt_o)
        else begin
            $error("read_gnt_o high in a cycle with a granted push");
            fail_count++;
        end

    exists_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exists_o |-> search_req_i)
        else begin
            $error("exists_o high without search_req_i");
            fail_count++;
        end

endmodule

/* id_queue_top.sv */
module id_queue_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  id_queue_pkg::push_req_t   push_i,
    input  logic                      push_req_i,
    output logic                      push_gnt_o,
    input  id_queue_pkg::read_req_t   read_i,
    input  logic                      read_req_i,
    output logic                      read_gnt_o,
    output id_queue_pkg::data_t       read_data_o,
    output logic                      read_valid_o,
    input  id_queue_pkg::search_req_t search_i,
    input  logic                      search_req_i,
    output logic                      search_gnt_o,
    output logic                      exists_o
);
    import id_queue_pkg::*;

    id_t                         lookup_id;
    ht_cmd_t                     ht_cmd;
    ld_cmd_t                     ld_cmd;
    logic                        match;
    head_tail_t                  match_entry;
    ht_idx_t                     ht_free_idx;
    ld_idx_t                     ld_free_idx;
    linked_data_t                head_elem;
    logic                        full;
    linked_data_t [CAPACITY-1:0] elems;

    id_queue_ctrl u_ctrl (
        .push_i        (push_i),
        .push_req_i    (push_req_i),
        .read_i        (read_i),
        .read_req_i    (read_req_i),
        .full_i        (full),
        .match_i       (match),
        .match_entry_i (match_entry),
        .ht_free_idx_i (ht_free_idx),
        .ld_free_idx_i (ld_free_idx),
        .head_elem_i   (head_elem),
        .lookup_id_o   (lookup_id),
        .ht_cmd_o      (ht_cmd),
        .ld_cmd_o      (ld_cmd),
        .push_gnt_o    (push_gnt_o),
        .read_gnt_o    (read_gnt_o),
        .read_data_o   (read_data_o),
        .read_valid_o  (read_valid_o)
    );

    head_tail_table u_ht (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .lookup_id_i   (lookup_id),
        .cmd_i         (ht_cmd),
        .match_o       (match),
        .match_entry_o (match_entry),
        .free_idx_o    (ht_free_idx)
    );

    // The element store serves the head of whichever ID the table matched
    linked_data_store u_ld (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .head_idx_i  (match_entry.head),
        .cmd_i       (ld_cmd),
        .head_elem_o (head_elem),
        .free_idx_o  (ld_free_idx),
        .full_o      (full),
        .elems_o     (elems)
    );

    exists_search u_exists (
        .elems_i      (elems),
        .search_i     (search_i),
        .search_req_i (search_req_i),
        .search_gnt_o (search_gnt_o),
        .exists_o     (exists_o)
    );

endmodule

/* linked_data_store.sv */
module linked_data_store (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    input  id_queue_pkg::ld_idx_t                             head_idx_i,
    input  id_queue_pkg::ld_cmd_t                             cmd_i,
    output id_queue_pkg::linked_data_t                        head_elem_o,
    output id_queue_pkg::ld_idx_t                             free_idx_o,
    output logic                                              full_o,
    output id_queue_pkg::linked_data_t [id_queue_pkg::CAPACITY-1:0] elems_o
);
    import id_queue_pkg::*;

    linked_data_t [CAPACITY-1:0] elem_q;
    logic [CAPACITY-1:0]         free_vec;

    always_comb begin
        for (int i = 0; i < CAPACITY; i++) begin
            free_vec[i] = elem_q[i].free;
        end
    end

    // Lowest free element, where the next push lands
    always_comb begin
        free_idx_o = '0;
        for (int i = CAPACITY - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                free_idx_o = ld_idx_t'(i);
            end
        end
    end

    // Capacity is shared by all IDs, so the queue is full once no element is free
    assign full_o = ~|free_vec;

    // The control reads the oldest element of the matched ID through this port
    assign head_elem_o = elem_q[head_idx_i];

    // The search compares against every element in parallel
    assign elems_o = elem_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < CAPACITY; i++) begin
                elem_q[i] <= '{data: '0, next: '0, free: 1'b1};
            end
        end else begin
            case (cmd_i.op)
                OP_PUSH: begin
                    // A new element is always the youngest of its ID and has no successor
                    elem_q[cmd_i.idx] <= '{data: cmd_i.data, next: '0, free: 1'b0};
                    // The old tail of the ID now points at the new element
                    if (cmd_i.link_en) begin
                        elem_q[cmd_i.link].next <= cmd_i.idx;
                    end
                end
                OP_POP: begin
                    elem_q[cmd_i.idx] <= '{data: '0, next: '0, free: 1'b1};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* tb_id_queue.sv */
module tb_id_queue;
    import id_queue_pkg::*;

    // Number of cycle vectors in the stimulus file
    localparam int N_VEC = 25;
    // Each vector packs its fields into whole hex digits
    localparam int VEC_WIDTH = 104;
    localparam int RESET_CYCLES = 5;
    // Generous margin over the reset phase plus one cycle per vector
    localparam int TIMEOUT_CYCLES = 8 * N_VEC + 20;

    logic        clk_i;
    logic        rst_ni;
    push_req_t   push_i;
    logic        push_req_i;
    logic        push_gnt_o;
    read_req_t   read_i;
    logic        read_req_i;
    logic        read_gnt_o;
    data_t       read_data_o;
    logic        read_valid_o;
    search_req_t search_i;
    logic        search_req_i;
    logic        search_gnt_o;
    logic        exists_o;

    logic [VEC_WIDTH-1:0] vec_mem [N_VEC];
    int error_count;
    int check_count;
    int cycle_count;

    id_queue_top u_id_queue_top (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (push_i),
        .push_req_i   (push_req_i),
        .push_gnt_o   (push_gnt_o),
        .read_i       (read_i),
        .read_req_i   (read_req_i),
        .read_gnt_o   (read_gnt_o),
        .read_data_o  (read_data_o),
        .read_valid_o (read_valid_o),
        .search_i     (search_i),
        .search_req_i (search_req_i),
        .search_gnt_o (search_gnt_o),
        .exists_o     (exists_o)
    );

    // Handshake rules are watched from inside the top level
    bind id_queue_top id_queue_props u_props (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_req_i   (push_req_i),
        .push_gnt_o   (push_gnt_o),
        .read_gnt_o   (read_gnt_o),
        .read_valid_o (read_valid_o),
        .search_req_i (search_req_i),
        .exists_o     (exists_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Unpacks one vector onto the request ports
    task automatic apply_vector(input logic [VEC_WIDTH-1:0] v);
        push_req_i   <= v[100];
        push_i       <= '{id: v[98:96], data: v[95:80]};
        read_req_i   <= v[76];
        read_i       <= '{id: v[74:72], pop: v[68]};
        search_req_i <= v[64];
        search_i     <= '{data: v[63:48], mask: v[47:32]};
    endtask

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Outputs are combinational, so they are settled by the falling edge
    task automatic check_outputs(input logic [VEC_WIDTH-1:0] v);
        compare_value("push_gnt_o", 16'(v[28]), 16'(push_gnt_o));
        compare_value("read_gnt_o", 16'(v[24]), 16'(read_gnt_o));
        compare_value("read_valid_o", 16'(v[20]), 16'(read_valid_o));
        compare_value("read_data_o", v[19:4], read_data_o);
        // The search port never stalls, its grant follows the request
        compare_value("search_gnt_o", 16'(v[64]), 16'(search_gnt_o));
        compare_value("exists_o", 16'(v[0]), 16'(exists_o));
    endtask

    // A short or missing file leaves unknown bits in the vector memory
    task automatic check_vectors_loaded();
        for (int i = 0; i < N_VEC; i++) begin
            if ($isunknown(vec_mem[i])) begin
                error_count++;
                $display("vector %0d could not be read from id_queue_input.txt", i);
            end
        end
    endtask

    initial begin
        rst_ni       = 1'b0;
        push_i       = '0;
        push_req_i   = 1'b0;
        read_i       = '0;
        read_req_i   = 1'b0;
        search_i     = '0;
        search_req_i = 1'b0;
        error_count  = 0;
        check_count  = 0;
        $readmemh("id_queue_input.txt", vec_mem);
        check_vectors_loaded();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < N_VEC; i++) begin
            @(posedge clk_i);
            apply_vector(vec_mem[i]);
            @(negedge clk_i);
            check_outputs(vec_mem[i]);
        end
        @(posedge clk_i);
        // The assertions on the last vector finish their action blocks after this edge
        @(negedge clk_i);
        // Assertion failures count as errors too
        error_count += u_id_queue_top.u_props.fail_count;
        $display("errors: %0d (%0d from assertions), checks: %0d",
                 error_count, u_id_queue_top.u_props.fail_count, check_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog in case the vector loop never completes
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout after %0d cycles without reaching the end of the vectors",
                 cycle_count);
        $display("Test failed");
        $finish;
    end

endmodule
